// ==== source/pll_rcfg_pkg.sv ====
// PLL reconfiguration front end package
// Bus sizes, soft CSR register map, identifier and the channel address view
// shared by the splitter, the channel ports and the top level

package pll_rcfg_pkg;

  // Channel count and shared bus geometry
  localparam int unsigned NUM_CHANNELS   = 4;
  localparam int unsigned CHNL_SEL_BITS  = 2;
  localparam int unsigned CHNL_ADDR_BITS = 10;
  localparam int unsigned USER_ADDR_BITS = CHNL_SEL_BITS + CHNL_ADDR_BITS;
  localparam int unsigned USER_DATA_BITS = 32;
  localparam int unsigned CHNL_DATA_BITS = 8;

  // Soft CSR register index width and map
  localparam int unsigned CSR_IDX_BITS = 4;
  localparam logic [CSR_IDX_BITS-1:0] CSR_REG_STATUS = 4'd0;
  localparam logic [CSR_IDX_BITS-1:0] CSR_REG_CTRL   = 4'd1;
  localparam logic [CSR_IDX_BITS-1:0] CSR_REG_ID     = 4'd2;

  // Fixed identifier returned by the ID register
  localparam logic [CHNL_DATA_BITS-1:0] CSR_USER_ID = 8'h5A;

  // Depth of the status input synchronizers
  localparam int unsigned SYNC_STAGES = 2;

  // Soft CSR view of a channel address
  // bit 9 selects the local registers, low nibble picks the register
  typedef struct packed {
    logic                                 sel;
    logic [CHNL_ADDR_BITS-CSR_IDX_BITS-2:0] rsvd;
    logic [CSR_IDX_BITS-1:0]              idx;
  } rcfg_csr_addr_t;

  // One channel address, seen either as a hard register address
  // or as a soft CSR select plus index
  typedef union packed {
    logic [CHNL_ADDR_BITS-1:0] hw;
    rcfg_csr_addr_t            csr;
  } rcfg_addr_u;

endpackage

// ==== source/rcfg_if_splitter.sv ====
// Shared reconfiguration bus splitter
// Decodes the channel select from the upper address bits, raises the strobe
// of that channel only and narrows write data to the channel byte width.
// Read data and waitrequest come back from the selected channel.

`timescale 1ns/1ps

module rcfg_if_splitter
  import pll_rcfg_pkg::*;
(
  // Clock and reset are observed by the bound protocol checks only
  input  logic                                          reconfig_clk,
  input  logic                                          rst_n,

  // Shared bus from the user side
  input  logic                                          reconfig_read,
  input  logic                                          reconfig_write,
  input  logic [USER_ADDR_BITS-1:0]                     reconfig_address,
  input  logic [USER_DATA_BITS-1:0]                     reconfig_writedata,
  output logic [USER_DATA_BITS-1:0]                     reconfig_readdata,
  output logic                                          reconfig_waitrequest,

  // Split per channel buses
  output logic [NUM_CHANNELS-1:0]                       chnl_read,
  output logic [NUM_CHANNELS-1:0]                       chnl_write,
  output rcfg_addr_u [NUM_CHANNELS-1:0]                 chnl_address,
  output logic [NUM_CHANNELS-1:0][CHNL_DATA_BITS-1:0]   chnl_writedata,
  input  logic [NUM_CHANNELS-1:0][CHNL_DATA_BITS-1:0]   chnl_readdata,
  input  logic [NUM_CHANNELS-1:0]                       chnl_waitrequest
);

  logic [CHNL_SEL_BITS-1:0] chnl_sel;
  logic [CHNL_DATA_BITS-1:0] sel_readdata;

  // Channel number sits directly above the per-channel address
  assign chnl_sel = reconfig_address[CHNL_ADDR_BITS +: CHNL_SEL_BITS];

  // Fan out to all channels, only the addressed one sees a strobe
  always_comb begin
    for (int i = 0; i < NUM_CHANNELS; i++) begin
      chnl_read[i]       = reconfig_read  & (chnl_sel == CHNL_SEL_BITS'(i));
      chnl_write[i]      = reconfig_write & (chnl_sel == CHNL_SEL_BITS'(i));
      chnl_address[i].hw = reconfig_address[CHNL_ADDR_BITS-1:0];
      // Upper bytes of the shared write data are dropped
      chnl_writedata[i]  = reconfig_writedata[CHNL_DATA_BITS-1:0];
    end
  end

  // Return path from the selected channel
  assign sel_readdata = chnl_readdata[chnl_sel];

  assign reconfig_readdata    = {{(USER_DATA_BITS-CHNL_DATA_BITS){1'b0}}, sel_readdata};
  assign reconfig_waitrequest = chnl_waitrequest[chnl_sel];

endmodule

// ==== source/chnl_csr_port.sv ====
// Per channel CSR port
// Steers each access either to the transceiver bus or to the local soft CSR
// block, which holds synchronized status, a powerdown override and an ID

`timescale 1ns/1ps

module chnl_csr_port
  import pll_rcfg_pkg::*;
(
  input  logic                        reconfig_clk,
  input  logic                        rst_n,

  // Channel bus from the splitter
  input  logic                        chnl_read,
  input  logic                        chnl_write,
  input  rcfg_addr_u                  chnl_address,
  input  logic [CHNL_DATA_BITS-1:0]   chnl_writedata,
  output logic [CHNL_DATA_BITS-1:0]   chnl_readdata,
  output logic                        chnl_waitrequest,

  // Transceiver register bus
  output logic                        avmm_read,
  output logic                        avmm_write,
  output logic [CHNL_ADDR_BITS-1:0]   avmm_address,
  output logic [CHNL_DATA_BITS-1:0]   avmm_writedata,
  input  logic [CHNL_DATA_BITS-1:0]   avmm_readdata,
  input  logic                        avmm_waitrequest,

  // PLL status and powerdown
  input  logic                        in_pll_powerdown,
  input  logic                        in_pll_locked,
  input  logic                        in_pll_cal_busy,
  input  logic                        in_avmm_busy,
  output logic                        out_pll_powerdown
);

  logic                             csr_sel;
  logic                             csr_read;
  logic                             csr_write;
  logic                             csr_ack_q;
  logic [CHNL_DATA_BITS-1:0]        csr_readdata;

  logic [2:0]                       stat_in;
  logic [SYNC_STAGES-1:0][2:0]      stat_sync_q;
  logic [2:0]                       stat_sync;

  // bit 0 override enable, bit 1 override value
  logic [1:0]                       ctrl_q;

  // Address bit 9 picks the soft CSR block
  assign csr_sel   = chnl_address.csr.sel;
  assign csr_read  = chnl_read  & csr_sel;
  assign csr_write = chnl_write & csr_sel;

  // Hard register path, a CSR access never shows up here
  assign avmm_read      = chnl_read  & ~csr_sel;
  assign avmm_write     = chnl_write & ~csr_sel;
  assign avmm_address   = chnl_address.hw;
  assign avmm_writedata = chnl_writedata;

  // CSR handshake
  // First cycle of a strobe stalls, the second one completes
  always_ff @(posedge reconfig_clk or negedge rst_n) begin
    if (!rst_n) begin
      csr_ack_q <= 1'b0;
    end else begin
      csr_ack_q <= (csr_read | csr_write) & ~csr_ack_q;
    end
  end

  // Status synchronizers for locked, cal_busy and avmm_busy
  assign stat_in = {in_avmm_busy, in_pll_cal_busy, in_pll_locked};

  always_ff @(posedge reconfig_clk or negedge rst_n) begin
    if (!rst_n) begin
      stat_sync_q <= '0;
    end else begin
      stat_sync_q <= {stat_sync_q[SYNC_STAGES-2:0], stat_in};
    end
  end

  assign stat_sync = stat_sync_q[SYNC_STAGES-1];

  // Control register, written on the completing edge
  always_ff @(posedge reconfig_clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_q <= 2'b00;
    end else if (csr_write && csr_ack_q && chnl_address.csr.idx == CSR_REG_CTRL) begin
      ctrl_q <= chnl_writedata[1:0];
    end
  end

  // CSR read mux
  always_comb begin
    case (chnl_address.csr.idx)
      CSR_REG_STATUS: csr_readdata = {4'b0000, in_pll_powerdown, stat_sync};
      CSR_REG_CTRL:   csr_readdata = {6'b000000, ctrl_q};
      CSR_REG_ID:     csr_readdata = CSR_USER_ID;
      default:        csr_readdata = '0;
    endcase
  end

  // Return path back to the splitter
  assign chnl_waitrequest = csr_sel ? ~csr_ack_q   : avmm_waitrequest;
  assign chnl_readdata    = csr_sel ? csr_readdata : avmm_readdata;

  // Powerdown follows the input unless the override is on
  assign out_pll_powerdown = ctrl_q[0] ? ctrl_q[1] : in_pll_powerdown;

endmodule

// ==== source/pll_rcfg_top.sv ====
// PLL reconfiguration front end top level
// One shared reconfiguration bus split over four channels, each with its
// own transceiver register bus and soft CSR block

`timescale 1ns/1ps

module pll_rcfg_top
  import pll_rcfg_pkg::*;
(
  input  logic                                          reconfig_clk,
  input  logic                                          rst_n,

  // Shared reconfiguration bus
  input  logic                                          reconfig_read,
  input  logic                                          reconfig_write,
  input  logic [USER_ADDR_BITS-1:0]                     reconfig_address,
  input  logic [USER_DATA_BITS-1:0]                     reconfig_writedata,
  output logic [USER_DATA_BITS-1:0]                     reconfig_readdata,
  output logic                                          reconfig_waitrequest,

  // Transceiver register buses, one per channel
  output logic [NUM_CHANNELS-1:0]                       avmm_read,
  output logic [NUM_CHANNELS-1:0]                       avmm_write,
  output logic [NUM_CHANNELS-1:0][CHNL_ADDR_BITS-1:0]   avmm_address,
  output logic [NUM_CHANNELS-1:0][CHNL_DATA_BITS-1:0]   avmm_writedata,
  input  logic [NUM_CHANNELS-1:0][CHNL_DATA_BITS-1:0]   avmm_readdata,
  input  logic [NUM_CHANNELS-1:0]                       avmm_waitrequest,

  // PLL status in, powerdown out per channel
  input  logic                                          in_pll_powerdown,
  input  logic                                          in_pll_locked,
  input  logic                                          in_pll_cal_busy,
  input  logic                                          in_avmm_busy,
  output logic [NUM_CHANNELS-1:0]                       out_pll_powerdown
);

  logic [NUM_CHANNELS-1:0]                      chnl_read;
  logic [NUM_CHANNELS-1:0]                      chnl_write;
  rcfg_addr_u [NUM_CHANNELS-1:0]                chnl_address;
  logic [NUM_CHANNELS-1:0][CHNL_DATA_BITS-1:0]  chnl_writedata;
  logic [NUM_CHANNELS-1:0][CHNL_DATA_BITS-1:0]  chnl_readdata;
  logic [NUM_CHANNELS-1:0]                      chnl_waitrequest;

  rcfg_if_splitter i_rcfg_if_splitter (
    .reconfig_clk         (reconfig_clk),
    .rst_n                (rst_n),
    .reconfig_read        (reconfig_read),
    .reconfig_write       (reconfig_write),
    .reconfig_address     (reconfig_address),
    .reconfig_writedata   (reconfig_writedata),
    .reconfig_readdata    (reconfig_readdata),
    .reconfig_waitrequest (reconfig_waitrequest),
    .chnl_read            (chnl_read),
    .chnl_write           (chnl_write),
    .chnl_address         (chnl_address),
    .chnl_writedata       (chnl_writedata),
    .chnl_readdata        (chnl_readdata),
    .chnl_waitrequest     (chnl_waitrequest)
  );

  // One CSR port per channel
  for (genvar g = 0; g < NUM_CHANNELS; g++) begin : g_chnl
    chnl_csr_port i_chnl_csr_port (
      .reconfig_clk      (reconfig_clk),
      .rst_n             (rst_n),
      .chnl_read         (chnl_read[g]),
      .chnl_write        (chnl_write[g]),
      .chnl_address      (chnl_address[g]),
      .chnl_writedata    (chnl_writedata[g]),
      .chnl_readdata     (chnl_readdata[g]),
      .chnl_waitrequest  (chnl_waitrequest[g]),
      .avmm_read         (avmm_read[g]),
      .avmm_write        (avmm_write[g]),
      .avmm_address      (avmm_address[g]),
      .avmm_writedata    (avmm_writedata[g]),
      .avmm_readdata     (avmm_readdata[g]),
      .avmm_waitrequest  (avmm_waitrequest[g]),
      .in_pll_powerdown  (in_pll_powerdown),
      .in_pll_locked     (in_pll_locked),
      .in_pll_cal_busy   (in_pll_cal_busy),
      .in_avmm_busy      (in_avmm_busy),
      .out_pll_powerdown (out_pll_powerdown[g])
    );
  end

endmodule

// ==== verif/pll_rcfg_assertions.sv ====
// Protocol checks for the PLL reconfiguration front end
// Bound into the top level, watches the per channel transceiver buses

`timescale 1ns/1ps

module pll_rcfg_assertions
  import pll_rcfg_pkg::*;
(
  input logic                                        reconfig_clk,
  input logic                                        rst_n,
  input logic [NUM_CHANNELS-1:0]                     avmm_read,
  input logic [NUM_CHANNELS-1:0]                     avmm_write,
  input logic [NUM_CHANNELS-1:0][CHNL_ADDR_BITS-1:0] avmm_address,
  input logic [NUM_CHANNELS-1:0][CHNL_DATA_BITS-1:0] avmm_writedata,
  input logic [NUM_CHANNELS-1:0]                     avmm_waitrequest
);

  // Failure count, read by the testbench at the end of the run
  int unsigned assert_errors = 0;

  // Only one channel may be addressed at a time
  a_one_channel: assert property (@(posedge reconfig_clk) disable iff (!rst_n)
    $onehot0(avmm_read | avmm_write))
    else begin
      $error("more than one transceiver strobe active");
      assert_errors++;
    end

  a_no_rd_wr: assert property (@(posedge reconfig_clk) disable iff (!rst_n)
    (avmm_read & avmm_write) == '0)
    else begin
      $error("read and write active together on one channel");
      assert_errors++;
    end

  a_reset_idle: assert property (@(posedge reconfig_clk)
    !rst_n |-> (avmm_read == '0) && (avmm_write == '0))
    else begin
      $error("transceiver strobe active during reset");
      assert_errors++;
    end

  // A stalled access keeps strobe, address and data
  for (genvar g = 0; g < NUM_CHANNELS; g++) begin : g_hold
    a_hold: assert property (@(posedge reconfig_clk) disable iff (!rst_n)
      (avmm_read[g] || avmm_write[g]) && avmm_waitrequest[g] |=>
        $stable(avmm_read[g]) && $stable(avmm_write[g]) &&
        $stable(avmm_address[g]) && $stable(avmm_writedata[g]))
      else begin
        $error("transceiver bus changed while stalled");
        assert_errors++;
      end
  end

endmodule

bind pll_rcfg_top pll_rcfg_assertions i_pll_rcfg_assertions (.*);

// ==== verif/tb_pll_rcfg.sv ====
// Testbench for the PLL reconfiguration front end
// Random shared bus traffic checked against a transceiver memory model
// and a model of the soft CSR registers of every channel

`timescale 1ns/1ps

module tb_pll_rcfg
  import pll_rcfg_pkg::*;
();

  logic                                        reconfig_clk;
  logic                                        rst_n;
  logic                                        reconfig_read;
  logic                                        reconfig_write;
  logic [USER_ADDR_BITS-1:0]                   reconfig_address;
  logic [USER_DATA_BITS-1:0]                   reconfig_writedata;
  logic [USER_DATA_BITS-1:0]                   reconfig_readdata;
  logic                                        reconfig_waitrequest;
  logic [NUM_CHANNELS-1:0]                     avmm_read;
  logic [NUM_CHANNELS-1:0]                     avmm_write;
  logic [NUM_CHANNELS-1:0][CHNL_ADDR_BITS-1:0] avmm_address;
  logic [NUM_CHANNELS-1:0][CHNL_DATA_BITS-1:0] avmm_writedata;
  logic [NUM_CHANNELS-1:0][CHNL_DATA_BITS-1:0] avmm_readdata;
  logic [NUM_CHANNELS-1:0]                     avmm_waitrequest;
  logic                                        in_pll_powerdown;
  logic                                        in_pll_locked;
  logic                                        in_pll_cal_busy;
  logic                                        in_avmm_busy;
  logic [NUM_CHANNELS-1:0]                     out_pll_powerdown;

  integer seed = 32'h6ce630cd;

  // Transceiver register contents and stall cycles left per channel
  logic [CHNL_DATA_BITS-1:0] xcvr_mem [NUM_CHANNELS][1024];
  int unsigned               stretch [NUM_CHANNELS];
  // Expected control register of every channel
  logic [1:0]                ctrl_model [NUM_CHANNELS];

  pll_rcfg_top i_pll_rcfg_top (.*);

  initial begin
    reconfig_clk = 1'b0;
    forever #5 reconfig_clk = ~reconfig_clk;
  end

  // Transceiver model, waitrequest is high until the stall has run out
  always @(posedge reconfig_clk) begin
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      if ((avmm_read[c] || avmm_write[c]) && !avmm_waitrequest[c]) begin
        if (avmm_write[c]) begin
          xcvr_mem[c][avmm_address[c]] <= avmm_writedata[c];
        end
        avmm_waitrequest[c] <= 1'b1;
        stretch[c]          <= $unsigned($random(seed)) % 4;
      end else if (avmm_read[c] || avmm_write[c]) begin
        if (stretch[c] == 0) begin
          avmm_waitrequest[c] <= 1'b0;
          avmm_readdata[c]    <= xcvr_mem[c][avmm_address[c]];
        end else begin
          stretch[c] <= stretch[c] - 1;
        end
      end else begin
        avmm_waitrequest[c] <= 1'b1;
      end
    end
  end

  task automatic fail_run(input string line);
    $display("%s", line);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_readdata(input string name, input logic [USER_DATA_BITS-1:0] got,
                                input logic [USER_DATA_BITS-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_chnl_addr(input string name, input rcfg_addr_u got,
                                 input rcfg_addr_u exp);
    if (got !== exp) begin
      fail_run($sformatf("error: %s got 0x%h expected 0x%h", name, got.hw, exp.hw));
    end
  endtask

  task automatic check_powerdown(input logic [NUM_CHANNELS-1:0] got,
                                 input logic [NUM_CHANNELS-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("error: out_pll_powerdown got 0x%h expected 0x%h", got, exp));
    end
  endtask

  task automatic check_strobes(input string name, input logic [NUM_CHANNELS-1:0] got,
                               input logic [NUM_CHANNELS-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // Override forces a channel, otherwise it follows the input
  function automatic logic [NUM_CHANNELS-1:0] expected_powerdown();
    logic [NUM_CHANNELS-1:0] pd;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      pd[c] = ctrl_model[c][0] ? ctrl_model[c][1] : in_pll_powerdown;
    end
    return pd;
  endfunction

  // CSR address with random reserved bits
  function automatic logic [USER_ADDR_BITS-1:0] make_csr_address(
      input int chnl, input logic [CSR_IDX_BITS-1:0] idx);
    rcfg_addr_u a;
    a.csr.sel  = 1'b1;
    a.csr.rsvd = $random(seed);
    a.csr.idx  = idx;
    return {CHNL_SEL_BITS'(chnl), a.hw};
  endfunction

  // One shared bus access, checking the transceiver side every cycle
  task automatic bus_access(input logic is_write, input logic [USER_ADDR_BITS-1:0] addr,
                            input logic [USER_DATA_BITS-1:0] wdata,
                            output logic [USER_DATA_BITS-1:0] rdata);
    int                      chnl;
    int                      stalls;
    logic                    done;
    rcfg_addr_u              caddr;
    rcfg_addr_u              seen;
    logic [NUM_CHANNELS-1:0] exp_rd;
    logic [NUM_CHANNELS-1:0] exp_wr;
    chnl     = addr[USER_ADDR_BITS-1 -: CHNL_SEL_BITS];
    caddr.hw = addr[CHNL_ADDR_BITS-1:0];
    exp_rd   = '0;
    exp_wr   = '0;
    if (!caddr.csr.sel) begin
      exp_rd[chnl] = !is_write;
      exp_wr[chnl] = is_write;
    end
    @(posedge reconfig_clk);
    reconfig_read      <= !is_write;
    reconfig_write     <= is_write;
    reconfig_address   <= addr;
    reconfig_writedata <= wdata;
    stalls = 0;
    done   = 1'b0;
    while (!done) begin
      @(posedge reconfig_clk);
      check_strobes("avmm_read", avmm_read, exp_rd);
      check_strobes("avmm_write", avmm_write, exp_wr);
      if (!caddr.csr.sel) begin
        seen.hw = avmm_address[chnl];
        check_chnl_addr("avmm_address", seen, caddr);
        if (is_write) begin
          check_readdata("avmm_writedata", USER_DATA_BITS'(avmm_writedata[chnl]),
                         USER_DATA_BITS'(wdata[CHNL_DATA_BITS-1:0]));
        end
      end
      if (!reconfig_waitrequest) begin
        done  = 1'b1;
        rdata = reconfig_readdata;
      end else begin
        stalls++;
        if (stalls >= 50) begin
          fail_run("shared bus access got no completion within 50 cycles");
        end
      end
    end
    reconfig_read  <= 1'b0;
    reconfig_write <= 1'b0;
    if (caddr.csr.sel && stalls != 1) begin
      fail_run("CSR access did not complete in exactly two cycles");
    end
  endtask

  task automatic write_hw_reg();
    int                        chnl;
    logic [CHNL_ADDR_BITS-1:0] addr;
    logic [USER_DATA_BITS-1:0] wdata;
    logic [USER_DATA_BITS-1:0] rdata;
    chnl  = $unsigned($random(seed)) % NUM_CHANNELS;
    addr  = $random(seed);
    addr[CHNL_ADDR_BITS-1] = 1'b0;
    wdata = $random(seed);
    bus_access(1'b1, {CHNL_SEL_BITS'(chnl), addr}, wdata, rdata);
    // Model memory takes the byte at the completing edge
    @(negedge reconfig_clk);
    check_readdata("model memory", USER_DATA_BITS'(xcvr_mem[chnl][addr]),
                   USER_DATA_BITS'(wdata[CHNL_DATA_BITS-1:0]));
  endtask

  task automatic read_hw_reg();
    int                        chnl;
    logic [CHNL_ADDR_BITS-1:0] addr;
    logic [USER_DATA_BITS-1:0] exp;
    logic [USER_DATA_BITS-1:0] rdata;
    chnl = $unsigned($random(seed)) % NUM_CHANNELS;
    addr = $random(seed);
    addr[CHNL_ADDR_BITS-1] = 1'b0;
    exp  = USER_DATA_BITS'(xcvr_mem[chnl][addr]);
    bus_access(1'b0, {CHNL_SEL_BITS'(chnl), addr}, $random(seed), rdata);
    check_readdata("reconfig_readdata", rdata, exp);
  endtask

  task automatic read_status();
    int                        chnl;
    logic [USER_DATA_BITS-1:0] exp;
    logic [USER_DATA_BITS-1:0] rdata;
    @(posedge reconfig_clk);
    in_pll_powerdown <= $random(seed);
    in_pll_locked    <= $random(seed);
    in_pll_cal_busy  <= $random(seed);
    in_avmm_busy     <= $random(seed);
    // Hold long enough to pass the synchronizers
    repeat (SYNC_STAGES + 3) @(posedge reconfig_clk);
    check_powerdown(out_pll_powerdown, expected_powerdown());
    chnl = $unsigned($random(seed)) % NUM_CHANNELS;
    exp  = USER_DATA_BITS'({in_pll_powerdown, in_avmm_busy, in_pll_cal_busy, in_pll_locked});
    bus_access(1'b0, make_csr_address(chnl, CSR_REG_STATUS), $random(seed), rdata);
    check_readdata("status register", rdata, exp);
  endtask

  task automatic set_override();
    int                        chnl;
    logic [USER_DATA_BITS-1:0] wdata;
    logic [USER_DATA_BITS-1:0] rdata;
    chnl  = $unsigned($random(seed)) % NUM_CHANNELS;
    wdata = $random(seed);
    bus_access(1'b1, make_csr_address(chnl, CSR_REG_CTRL), wdata, rdata);
    ctrl_model[chnl] = wdata[1:0];
    @(negedge reconfig_clk);
    check_powerdown(out_pll_powerdown, expected_powerdown());
    bus_access(1'b0, make_csr_address(chnl, CSR_REG_CTRL), $random(seed), rdata);
    check_readdata("control readback", rdata, USER_DATA_BITS'(ctrl_model[chnl]));
  endtask

  task automatic read_identifier();
    int                        chnl;
    logic [CSR_IDX_BITS-1:0]   idx;
    logic [USER_DATA_BITS-1:0] rdata;
    chnl = $unsigned($random(seed)) % NUM_CHANNELS;
    bus_access(1'b0, make_csr_address(chnl, CSR_REG_ID), $random(seed), rdata);
    check_readdata("identifier", rdata, 32'h0000_005A);
    // Indexes above the identifier are unused
    idx = 3 + $unsigned($random(seed)) % 13;
    bus_access(1'b0, make_csr_address(chnl, idx), $random(seed), rdata);
    check_readdata("unused CSR index", rdata, '0);
  endtask

  initial begin
    int op;
    rst_n              = 1'b0;
    reconfig_read      = 1'b0;
    reconfig_write     = 1'b0;
    reconfig_address   = '0;
    reconfig_writedata = '0;
    avmm_readdata      = '0;
    avmm_waitrequest   = '1;
    in_pll_powerdown   = $random(seed);
    in_pll_locked      = 1'b0;
    in_pll_cal_busy    = 1'b0;
    in_avmm_busy       = 1'b0;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      for (int a = 0; a < 1024; a++) begin
        xcvr_mem[c][a] = CHNL_DATA_BITS'(a ^ (a >> 3) ^ (c * 37));
      end
      stretch[c]    = $unsigned($random(seed)) % 4;
      ctrl_model[c] = 2'b00;
    end
    repeat (16) @(posedge reconfig_clk);
    rst_n <= 1'b1;
    @(negedge reconfig_clk);
    check_strobes("avmm_read", avmm_read, '0);
    check_strobes("avmm_write", avmm_write, '0);
    check_powerdown(out_pll_powerdown, {NUM_CHANNELS{in_pll_powerdown}});
    for (int n = 0; n < 400; n++) begin
      op = $unsigned($random(seed)) % 8;
      case (op)
        0, 1, 2: write_hw_reg();
        3, 4:    read_hw_reg();
        5:       read_status();
        6:       set_override();
        default: read_identifier();
      endcase
    end
    @(posedge reconfig_clk);
    if (i_pll_rcfg_top.i_pll_rcfg_assertions.assert_errors == 0) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      fail_run("a bound protocol assertion failed during the run");
    end
  end

endmodule

// ==== vlog.f ====
source/pll_rcfg_pkg.sv
source/rcfg_if_splitter.sv
source/chnl_csr_port.sv
source/pll_rcfg_top.sv
verif/pll_rcfg_assertions.sv
verif/tb_pll_rcfg.sv

// ==== Bender.yml ====
package:
  name: pll_rcfg

sources:
  # RTL, package first
  - files:
      - source/pll_rcfg_pkg.sv
      - source/rcfg_if_splitter.sv
      - source/chnl_csr_port.sv
      - source/pll_rcfg_top.sv

  # Verification sources
  - target: test
    files:
      - verif/pll_rcfg_assertions.sv
      - verif/tb_pll_rcfg.sv
